// File: design/cpu_isa_pkg.sv
package cpu_isa_pkg;

	typedef logic [31:0] word_t;

	// low holds sv in 9:8 and the sub-opcodes below it
	typedef struct packed {
		logic       unused;
		logic [5:0] opcode;
		logic [4:0] rt;
		logic [4:0] ra;
		logic [4:0] rb;
		logic [9:0] low;
	} instr_t;

	// major opcodes
	localparam logic [5:0] op_base   = 6'b100000;
	localparam logic [5:0] op_addi   = 6'b101000;
	localparam logic [5:0] op_ori    = 6'b101100;
	localparam logic [5:0] op_xori   = 6'b101011;
	localparam logic [5:0] op_movi   = 6'b100010;
	localparam logic [5:0] op_lwi    = 6'b000010;
	localparam logic [5:0] op_swi    = 6'b001010;
	localparam logic [5:0] op_ls     = 6'b011100;
	localparam logic [5:0] op_branch = 6'b100110;
	localparam logic [5:0] op_jump   = 6'b100100;

	// sub-opcodes under op_base, low[4:0]
	localparam logic [4:0] sub_add   = 5'b00000;
	localparam logic [4:0] sub_sub   = 5'b00001;
	localparam logic [4:0] sub_and   = 5'b00010;
	localparam logic [4:0] sub_xor   = 5'b00011;
	localparam logic [4:0] sub_or    = 5'b00100;
	localparam logic [4:0] sub_slli  = 5'b01000;
	localparam logic [4:0] sub_srli  = 5'b01001;
	localparam logic [4:0] sub_rotri = 5'b01011;

	// sub-opcodes under op_ls, low[7:0]
	localparam logic [7:0] sub_lw = 8'b00000010;
	localparam logic [7:0] sub_sw = 8'b00001010;

endpackage

// File: design/cpu_ctrl_pkg.sv
package cpu_ctrl_pkg;

	typedef enum logic [2:0] {
		stage_fetch,
		stage_decode,
		stage_execute,
		stage_memaccess,
		stage_writeback
	} stage_t;

	typedef enum logic [2:0] {
		src2_rb,
		src2_imm,
		src2_lswi,
		src2_lsw,
		src2_branch,
		src2_none
	} alu_src2_t;

	typedef enum logic [2:0] {
		imm_none,
		imm_5_ze,
		imm_15_se,
		imm_15_ze,
		imm_20_se
	} imm_ext_t;

	typedef enum logic [1:0] {
		wr_alu,
		wr_imm,
		wr_mem,
		wr_none
	} write_reg_t;

	typedef struct packed {
		alu_src2_t  select_alu_src2;
		imm_ext_t   select_imm_extend;
		write_reg_t select_write_reg;
		logic       do_dm_read;
		logic       do_dm_write;
		logic       do_reg_write;
		logic       is_branch;
		logic       is_jump;
	} control_t;

	// decode result for anything that only advances the pc
	localparam control_t ctrl_nop = '{
		select_alu_src2:   src2_none,
		select_imm_extend: imm_none,
		select_write_reg:  wr_none,
		do_dm_read:        1'b0,
		do_dm_write:       1'b0,
		do_reg_write:      1'b0,
		is_branch:         1'b0,
		is_jump:           1'b0
	};

endpackage

// File: design/word_memory.sv
module word_memory #(
	parameter int  words     = 256,
	parameter type payload_t = cpu_isa_pkg::word_t
) (
	input  logic               clock,
	input  logic               write,
	input  cpu_isa_pkg::word_t write_address,
	input  payload_t           write_data,
	input  logic               read,
	input  cpu_isa_pkg::word_t read_address,
	output payload_t           read_data
);

	localparam int index_bits = $clog2(words);

	payload_t                storage [words];
	logic [index_bits-1:0] write_index;
	logic [index_bits-1:0] read_index;

	// byte addresses, word indexed
	assign write_index = write_address[index_bits+1:2];
	assign read_index  = read_address[index_bits+1:2];

	always_ff @(posedge clock) begin
		if (write) begin
			storage[write_index] <= write_data;
		end
	end

	always_ff @(posedge clock) begin
		if (read) begin
			read_data <= storage[read_index];
		end
	end

endmodule

// File: design/register_file.sv
module register_file (
	input  logic               clock,
	input  logic               reset,
	input  logic [4:0]         ra_address,
	input  logic [4:0]         rb_address,
	input  logic [4:0]         rt_address,
	input  logic               write,
	input  logic [4:0]         write_address,
	input  cpu_isa_pkg::word_t write_data,
	input  logic [4:0]         debug_address,
	output cpu_isa_pkg::word_t ra_data,
	output cpu_isa_pkg::word_t rb_data,
	output cpu_isa_pkg::word_t rt_data,
	output cpu_isa_pkg::word_t debug_data
);

	cpu_isa_pkg::word_t registers [32];

	// r0 is writable like any other
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				registers[i] <= '0;
			end
		end else if (write) begin
			registers[write_address] <= write_data;
		end
	end

	assign ra_data    = registers[ra_address];
	assign rb_data    = registers[rb_address];
	assign rt_data    = registers[rt_address];
	assign debug_data = registers[debug_address];

endmodule

// File: design/alu.sv
module alu (
	input  cpu_isa_pkg::instr_t    instr,
	input  cpu_ctrl_pkg::control_t control,
	input  cpu_isa_pkg::word_t     ra_data,
	input  cpu_isa_pkg::word_t     rb_data,
	input  cpu_isa_pkg::word_t     rt_data,
	input  cpu_isa_pkg::word_t     pc,
	output cpu_isa_pkg::word_t     result,
	output logic                   taken
);

	cpu_isa_pkg::word_t bits;
	cpu_isa_pkg::word_t imm;
	cpu_isa_pkg::word_t operand2;
	cpu_isa_pkg::word_t jump_offset;
	logic [4:0]         shamt;

	assign bits = instr;

	always_comb begin
		case (control.select_imm_extend)
			cpu_ctrl_pkg::imm_5_ze:  imm = {27'd0, bits[14:10]};
			cpu_ctrl_pkg::imm_15_se: imm = {{17{bits[14]}}, bits[14:0]};
			cpu_ctrl_pkg::imm_15_ze: imm = {17'd0, bits[14:0]};
			cpu_ctrl_pkg::imm_20_se: imm = {{12{bits[19]}}, bits[19:0]};
			default:                 imm = '0;
		endcase
	end

	// word offsets for lwi/swi, halfword offsets for branches
	always_comb begin
		case (control.select_alu_src2)
			cpu_ctrl_pkg::src2_rb:     operand2 = rb_data;
			cpu_ctrl_pkg::src2_imm:    operand2 = imm;
			cpu_ctrl_pkg::src2_lswi:   operand2 = {{15{bits[14]}}, bits[14:0], 2'b00};
			cpu_ctrl_pkg::src2_lsw:    operand2 = rb_data << instr.low[9:8];
			cpu_ctrl_pkg::src2_branch: operand2 = {{17{bits[13]}}, bits[13:0], 1'b0};
			default:                   operand2 = '0;
		endcase
	end

	assign jump_offset = {{7{bits[23]}}, bits[23:0], 1'b0};
	assign shamt       = operand2[4:0];

	always_comb begin
		case (instr.opcode)
			cpu_isa_pkg::op_base: begin
				case (instr.low[4:0])
					cpu_isa_pkg::sub_add:   result = ra_data + operand2;
					cpu_isa_pkg::sub_sub:   result = ra_data - operand2;
					cpu_isa_pkg::sub_and:   result = ra_data & operand2;
					cpu_isa_pkg::sub_or:    result = ra_data | operand2;
					cpu_isa_pkg::sub_xor:   result = ra_data ^ operand2;
					cpu_isa_pkg::sub_slli:  result = ra_data << shamt;
					cpu_isa_pkg::sub_srli:  result = ra_data >> shamt;
					cpu_isa_pkg::sub_rotri: begin
						result = (ra_data >> shamt) | (ra_data << (6'd32 - {1'b0, shamt}));
					end
					default:                result = '0;
				endcase
			end
			cpu_isa_pkg::op_addi:   result = ra_data + operand2;
			cpu_isa_pkg::op_ori:    result = ra_data | operand2;
			cpu_isa_pkg::op_xori:   result = ra_data ^ operand2;
			cpu_isa_pkg::op_movi:   result = operand2;
			cpu_isa_pkg::op_lwi, cpu_isa_pkg::op_swi,
			cpu_isa_pkg::op_ls:     result = ra_data + operand2;
			cpu_isa_pkg::op_branch: result = pc + operand2;
			cpu_isa_pkg::op_jump:   result = pc + jump_offset;
			default:                result = '0;
		endcase
	end

	// bit 14 set means bne
	assign taken = control.is_branch && (bits[14] ? (rt_data != ra_data) : (rt_data == ra_data));

endmodule

// File: design/controller.sv
module controller (
	input  logic                   clock,
	input  logic                   reset,
	input  cpu_isa_pkg::instr_t    instruction,
	output logic                   enable_fetch,
	output logic                   enable_decode,
	output logic                   enable_execute,
	output logic                   enable_memaccess,
	output logic                   enable_writeback,
	output cpu_isa_pkg::instr_t    instr,
	output cpu_ctrl_pkg::control_t control
);

	cpu_ctrl_pkg::stage_t stage;
	cpu_ctrl_pkg::stage_t stage_next;

	// ring through the five stages
	always_comb begin
		case (stage)
			cpu_ctrl_pkg::stage_fetch:     stage_next = cpu_ctrl_pkg::stage_decode;
			cpu_ctrl_pkg::stage_decode:    stage_next = cpu_ctrl_pkg::stage_execute;
			cpu_ctrl_pkg::stage_execute:   stage_next = cpu_ctrl_pkg::stage_memaccess;
			cpu_ctrl_pkg::stage_memaccess: stage_next = cpu_ctrl_pkg::stage_writeback;
			default:                       stage_next = cpu_ctrl_pkg::stage_fetch;
		endcase
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			stage <= cpu_ctrl_pkg::stage_fetch;
		end else begin
			stage <= stage_next;
		end
	end

	assign enable_fetch     = (stage == cpu_ctrl_pkg::stage_fetch);
	assign enable_decode    = (stage == cpu_ctrl_pkg::stage_decode);
	assign enable_execute   = (stage == cpu_ctrl_pkg::stage_execute);
	assign enable_memaccess = (stage == cpu_ctrl_pkg::stage_memaccess);
	assign enable_writeback = (stage == cpu_ctrl_pkg::stage_writeback);

	// instruction register
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			instr <= '0;
		end else if (enable_fetch) begin
			instr <= instruction;
		end
	end

	always_comb begin
		control = cpu_ctrl_pkg::ctrl_nop;
		case (instr.opcode)
			cpu_isa_pkg::op_base: begin
				case (instr.low[4:0])
					cpu_isa_pkg::sub_add, cpu_isa_pkg::sub_sub, cpu_isa_pkg::sub_and,
					cpu_isa_pkg::sub_or, cpu_isa_pkg::sub_xor: begin
						control.select_alu_src2  = cpu_ctrl_pkg::src2_rb;
						control.select_write_reg = cpu_ctrl_pkg::wr_alu;
						control.do_reg_write     = 1'b1;
					end
					cpu_isa_pkg::sub_slli, cpu_isa_pkg::sub_srli,
					cpu_isa_pkg::sub_rotri: begin
						control.select_alu_src2   = cpu_ctrl_pkg::src2_imm;
						control.select_imm_extend = cpu_ctrl_pkg::imm_5_ze;
						control.select_write_reg  = cpu_ctrl_pkg::wr_alu;
						control.do_reg_write      = 1'b1;
					end
					default: control = cpu_ctrl_pkg::ctrl_nop;
				endcase
			end
			cpu_isa_pkg::op_addi: begin
				control.select_alu_src2   = cpu_ctrl_pkg::src2_imm;
				control.select_imm_extend = cpu_ctrl_pkg::imm_15_se;
				control.select_write_reg  = cpu_ctrl_pkg::wr_alu;
				control.do_reg_write      = 1'b1;
			end
			cpu_isa_pkg::op_ori, cpu_isa_pkg::op_xori: begin
				control.select_alu_src2   = cpu_ctrl_pkg::src2_imm;
				control.select_imm_extend = cpu_ctrl_pkg::imm_15_ze;
				control.select_write_reg  = cpu_ctrl_pkg::wr_alu;
				control.do_reg_write      = 1'b1;
			end
			cpu_isa_pkg::op_movi: begin
				control.select_alu_src2   = cpu_ctrl_pkg::src2_imm;
				control.select_imm_extend = cpu_ctrl_pkg::imm_20_se;
				control.select_write_reg  = cpu_ctrl_pkg::wr_imm;
				control.do_reg_write      = 1'b1;
			end
			cpu_isa_pkg::op_lwi: begin
				control.select_alu_src2  = cpu_ctrl_pkg::src2_lswi;
				control.select_write_reg = cpu_ctrl_pkg::wr_mem;
				control.do_dm_read       = 1'b1;
				control.do_reg_write     = 1'b1;
			end
			cpu_isa_pkg::op_swi: begin
				control.select_alu_src2 = cpu_ctrl_pkg::src2_lswi;
				control.do_dm_write     = 1'b1;
			end
			cpu_isa_pkg::op_ls: begin
				case (instr.low[7:0])
					cpu_isa_pkg::sub_lw: begin
						control.select_alu_src2  = cpu_ctrl_pkg::src2_lsw;
						control.select_write_reg = cpu_ctrl_pkg::wr_mem;
						control.do_dm_read       = 1'b1;
						control.do_reg_write     = 1'b1;
					end
					cpu_isa_pkg::sub_sw: begin
						control.select_alu_src2 = cpu_ctrl_pkg::src2_lsw;
						control.do_dm_write     = 1'b1;
					end
					default: control = cpu_ctrl_pkg::ctrl_nop;
				endcase
			end
			cpu_isa_pkg::op_branch: begin
				control.select_alu_src2 = cpu_ctrl_pkg::src2_branch;
				control.is_branch       = 1'b1;
			end
			cpu_isa_pkg::op_jump: begin
				// jump offset is taken straight from the encoding
				control.is_jump = 1'b1;
			end
			default: control = cpu_ctrl_pkg::ctrl_nop;
		endcase
	end

endmodule

// File: design/cpu_top.sv
module cpu_top #(
	parameter int imem_words = 256,
	parameter int dmem_words = 256
) (
	input  logic               clock,
	input  logic               reset,
	input  logic               prog_write,
	input  cpu_isa_pkg::word_t prog_address,
	input  cpu_isa_pkg::word_t prog_data,
	input  logic [4:0]         debug_address,
	output logic               retire,
	output cpu_isa_pkg::word_t retire_pc,
	output logic               wb_valid,
	output logic [4:0]         wb_address,
	output cpu_isa_pkg::word_t wb_data,
	output cpu_isa_pkg::word_t debug_data
);

	logic enable_fetch;
	logic enable_decode;
	logic enable_execute;
	logic enable_memaccess;
	logic enable_writeback;

	cpu_isa_pkg::instr_t    instr;
	cpu_isa_pkg::instr_t    imem_data;
	cpu_ctrl_pkg::control_t control;

	cpu_isa_pkg::word_t pc;
	cpu_isa_pkg::word_t pc_next;
	cpu_isa_pkg::word_t fetch_address;
	cpu_isa_pkg::word_t ra_data;
	cpu_isa_pkg::word_t rb_data;
	cpu_isa_pkg::word_t rt_data;
	cpu_isa_pkg::word_t ra_q;
	cpu_isa_pkg::word_t rb_q;
	cpu_isa_pkg::word_t rt_q;
	cpu_isa_pkg::word_t alu_result;
	cpu_isa_pkg::word_t result_q;
	cpu_isa_pkg::word_t dm_data;
	logic               alu_taken;
	logic               taken_q;
	logic               dm_read;
	logic               dm_write;
	logic               reg_write;

	controller i_controller (
		.clock,
		.reset,
		.instruction (imem_data),
		.enable_fetch,
		.enable_decode,
		.enable_execute,
		.enable_memaccess,
		.enable_writeback,
		.instr,
		.control
	);

	// look one pc ahead in writeback so the fetch word is ready in time
	assign pc_next = ((control.is_branch && taken_q) || control.is_jump) ?
		result_q : pc + 32'd4;
	assign fetch_address = enable_writeback ? pc_next : pc;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			pc <= '0;
		end else if (enable_writeback) begin
			pc <= pc_next;
		end
	end

	word_memory #(
		.words     (imem_words),
		.payload_t (cpu_isa_pkg::instr_t)
	) i_imem (
		.clock,
		.write         (prog_write),
		.write_address (prog_address),
		.write_data    (cpu_isa_pkg::instr_t'(prog_data)),
		.read          (1'b1),
		.read_address  (fetch_address),
		.read_data     (imem_data)
	);

	register_file i_register_file (
		.clock,
		.reset,
		.ra_address    (instr.ra),
		.rb_address    (instr.rb),
		.rt_address    (instr.rt),
		.write         (reg_write),
		.write_address (instr.rt),
		.write_data    (wb_data),
		.debug_address,
		.ra_data,
		.rb_data,
		.rt_data,
		.debug_data
	);

	always_ff @(posedge clock) begin
		if (enable_decode) begin
			ra_q <= ra_data;
			rb_q <= rb_data;
			rt_q <= rt_data;
		end
		if (enable_execute) begin
			result_q <= alu_result;
			taken_q  <= alu_taken;
		end
	end

	alu i_alu (
		.instr,
		.control,
		.ra_data (ra_q),
		.rb_data (rb_q),
		.rt_data (rt_q),
		.pc,
		.result  (alu_result),
		.taken   (alu_taken)
	);

	assign dm_read  = enable_memaccess && control.do_dm_read;
	assign dm_write = enable_memaccess && control.do_dm_write;

	word_memory #(
		.words     (dmem_words),
		.payload_t (cpu_isa_pkg::word_t)
	) i_dmem (
		.clock,
		.write         (dm_write),
		.write_address (result_q),
		.write_data    (rt_q),
		.read          (dm_read),
		.read_address  (result_q),
		.read_data     (dm_data)
	);

	// movi leaves its extended immediate in the result register
	always_comb begin
		case (control.select_write_reg)
			cpu_ctrl_pkg::wr_alu, cpu_ctrl_pkg::wr_imm: wb_data = result_q;
			cpu_ctrl_pkg::wr_mem:                       wb_data = dm_data;
			default:                                    wb_data = '0;
		endcase
	end

	assign reg_write  = enable_writeback && control.do_reg_write;
	assign retire     = enable_writeback;
	assign retire_pc  = pc;
	assign wb_valid   = reg_write;
	assign wb_address = instr.rt;

endmodule

// File: test/cpu_checker.sv
module cpu_checker (
	input logic clock,
	input logic reset,
	input logic enable_fetch,
	input logic enable_decode,
	input logic enable_execute,
	input logic enable_memaccess,
	input logic enable_writeback,
	input logic retire,
	input logic dm_write,
	input logic reg_write
);
	timeunit 1ns;
	timeprecision 100ps;

	int unsigned failures = 0;

	stages_one_hot: assert property (@(posedge clock) disable iff (reset)
		$onehot({enable_fetch, enable_decode, enable_execute, enable_memaccess,
			enable_writeback}))
	else begin
		failures++;
		$error("stage enables are not one-hot");
	end

	// writeback only ever follows the memory access stage
	retire_after_memaccess: assert property (@(posedge clock) disable iff (reset)
		retire |-> $past(enable_memaccess))
	else begin
		failures++;
		$error("retire not preceded by the memory access stage");
	end

	no_double_write: assert property (@(posedge clock) disable iff (reset)
		!(dm_write && reg_write))
	else begin
		failures++;
		$error("data memory and register file written together");
	end

	// next retire exactly five cycles later
	retire_spacing_next: assert property (@(posedge clock) disable iff (reset)
		retire |-> ##5 retire)
	else begin
		failures++;
		$error("retire not repeated after five cycles");
	end

	retire_spacing_gap: assert property (@(posedge clock) disable iff (reset)
		retire |-> !$past(retire, 1) && !$past(retire, 2) && !$past(retire, 3) &&
			!$past(retire, 4))
	else begin
		failures++;
		$error("retire pulses closer than five cycles");
	end

endmodule

// File: test/cpu_tb.sv
module cpu_tb;
	timeunit 1ns;
	timeprecision 100ps;

	logic               clock = 1'b0;
	logic               reset;
	logic               prog_write;
	cpu_isa_pkg::word_t prog_address;
	cpu_isa_pkg::word_t prog_data;
	logic [4:0]         debug_address;
	logic               retire;
	cpu_isa_pkg::word_t retire_pc;
	logic               wb_valid;
	logic [4:0]         wb_address;
	cpu_isa_pkg::word_t wb_data;
	cpu_isa_pkg::word_t debug_data;

	cpu_isa_pkg::word_t program_words[$];
	string              test_name;
	int                 error_count = 0;
	int                 test_errors = 0;
	int                 tests_run = 0;
	int                 tests_failed = 0;

	cpu_top #(
		.imem_words (256),
		.dmem_words (256)
	) i_dut (.*);

	bind cpu_top cpu_checker i_checker (
		.clock,
		.reset,
		.enable_fetch,
		.enable_decode,
		.enable_execute,
		.enable_memaccess,
		.enable_writeback,
		.retire,
		.dm_write,
		.reg_write
	);

	always #10 clock = ~clock;

	function automatic cpu_isa_pkg::word_t sext(input int width, input cpu_isa_pkg::word_t value);
		cpu_isa_pkg::word_t shifted;
		shifted = value << (32 - width);
		return $signed(shifted) >>> (32 - width);
	endfunction

	// shift immediates put the amount in the rb field
	function automatic cpu_isa_pkg::word_t reg_op(input logic [4:0] sub, input logic [4:0] rt,
			input logic [4:0] ra, input logic [4:0] rb);
		return {1'b0, cpu_isa_pkg::op_base, rt, ra, rb, 5'd0, sub};
	endfunction

	function automatic cpu_isa_pkg::word_t imm_op(input logic [5:0] op, input logic [4:0] rt,
			input logic [4:0] ra, input logic [14:0] imm);
		return {1'b0, op, rt, ra, imm};
	endfunction

	function automatic cpu_isa_pkg::word_t movi_op(input logic [4:0] rt, input logic [19:0] imm);
		return {1'b0, cpu_isa_pkg::op_movi, rt, imm};
	endfunction

	function automatic cpu_isa_pkg::word_t ls_op(input logic [7:0] sub, input logic [1:0] sv,
			input logic [4:0] rt, input logic [4:0] ra, input logic [4:0] rb);
		return {1'b0, cpu_isa_pkg::op_ls, rt, ra, rb, sv, sub};
	endfunction

	function automatic cpu_isa_pkg::word_t branch_op(input logic bne, input logic [4:0] rt,
			input logic [4:0] ra, input logic [13:0] offset);
		return {1'b0, cpu_isa_pkg::op_branch, rt, ra, bne, offset};
	endfunction

	function automatic cpu_isa_pkg::word_t jump_op(input logic [23:0] offset);
		return {1'b0, cpu_isa_pkg::op_jump, 1'b0, offset};
	endfunction

	task automatic check_word(input string what, input cpu_isa_pkg::word_t expected,
			input cpu_isa_pkg::word_t actual);
		if (actual !== expected) begin
			$display("MISMATCH %s %s: expected %h actual %h", test_name, what, expected, actual);
			error_count++;
		end
	endtask

	task automatic check_pc(input string what, input cpu_isa_pkg::word_t expected,
			input cpu_isa_pkg::word_t actual);
		if (actual !== expected) begin
			$display("MISMATCH %s retire_pc of %s: expected %h actual %h", test_name, what,
				expected, actual);
			error_count++;
		end
	endtask

	task automatic check_flag(input string what, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("MISMATCH %s wb_valid of %s: expected %b actual %b", test_name, what,
				expected, actual);
			error_count++;
		end
	endtask

	task automatic check_address(input string what, input logic [4:0] expected,
			input logic [4:0] actual);
		if (actual !== expected) begin
			$display("MISMATCH %s wb_address of %s: expected %0d actual %0d", test_name, what,
				expected, actual);
			error_count++;
		end
	endtask

	task automatic expect_retire(input string what, input cpu_isa_pkg::word_t exp_pc,
			input logic exp_valid, input cpu_isa_pkg::word_t exp_data);
		int                  waited;
		cpu_isa_pkg::instr_t exp_instr;
		waited = 0;
		@(negedge clock);
		while (!retire && waited < 12) begin
			@(negedge clock);
			waited++;
		end
		if (!retire) begin
			$display("%s %s: no retire within limit", test_name, what);
			error_count++;
		end else begin
			check_pc(what, exp_pc, retire_pc);
			check_flag(what, exp_valid, wb_valid);
			if (exp_valid) begin
				// destination is the rt field of the word at that pc
				exp_instr = program_words[exp_pc >> 2];
				check_address(what, exp_instr.rt, wb_address);
				check_word(what, exp_data, wb_data);
			end
		end
	endtask

	// only safe within the first cycles after a retire
	task automatic check_register(input logic [4:0] index, input cpu_isa_pkg::word_t expected);
		@(negedge clock);
		debug_address = index;
		#1;
		check_word($sformatf("debug r%0d", index), expected, debug_data);
	endtask

	// program is written while reset is held for 16 cycles
	task automatic start_program(input string name);
		test_name = name;
		test_errors = error_count;
		for (int i = 0; i < 16; i++) begin
			@(negedge clock);
			reset = 1'b1;
			prog_write = (i < program_words.size());
			prog_address = i * 4;
			prog_data = (i < program_words.size()) ? program_words[i] : '0;
		end
		@(negedge clock);
		reset = 1'b0;
		prog_write = 1'b0;
	endtask

	task automatic finish_test;
		tests_run++;
		if (error_count == test_errors) begin
			$display("%s: ok", test_name);
		end else begin
			tests_failed++;
			$display("%s: failed with %0d errors", test_name, error_count - test_errors);
		end
	endtask

	task automatic alu_reg_test;
		cpu_isa_pkg::word_t a;
		cpu_isa_pkg::word_t b;
		a = sext(20, $urandom);
		b = sext(20, $urandom);
		program_words.delete();
		program_words.push_back(movi_op(5'd1, a[19:0]));
		program_words.push_back(movi_op(5'd2, b[19:0]));
		program_words.push_back(reg_op(cpu_isa_pkg::sub_add, 5'd3, 5'd1, 5'd2));
		program_words.push_back(reg_op(cpu_isa_pkg::sub_sub, 5'd4, 5'd1, 5'd2));
		program_words.push_back(reg_op(cpu_isa_pkg::sub_and, 5'd5, 5'd1, 5'd2));
		program_words.push_back(reg_op(cpu_isa_pkg::sub_or, 5'd6, 5'd1, 5'd2));
		program_words.push_back(reg_op(cpu_isa_pkg::sub_xor, 5'd7, 5'd1, 5'd2));
		start_program("alu_reg");
		expect_retire("movi r1", 32'd0, 1'b1, a);
		expect_retire("movi r2", 32'd4, 1'b1, b);
		expect_retire("add", 32'd8, 1'b1, a + b);
		expect_retire("sub", 32'd12, 1'b1, a - b);
		expect_retire("and", 32'd16, 1'b1, a & b);
		expect_retire("or", 32'd20, 1'b1, a | b);
		expect_retire("xor", 32'd24, 1'b1, a ^ b);
		finish_test;
	endtask

	task automatic imm_test;
		cpu_isa_pkg::word_t c;
		cpu_isa_pkg::word_t r;
		logic [14:0]        ia;
		logic [14:0]        io;
		logic [14:0]        ix;
		logic [4:0]         s1;
		logic [4:0]         s2;
		logic [4:0]         s3;
		logic [63:0]        both;
		// bit 19 set so the sign extension shows
		c = sext(20, $urandom | 32'h0008_0000);
		r = $urandom;
		ia = {1'b1, r[13:0]};
		io = {1'b1, r[27:14]};
		s1 = r[31:27];
		r = $urandom;
		ix = {1'b1, r[13:0]};
		s2 = r[18:14];
		s3 = r[23:19];
		program_words.delete();
		program_words.push_back(movi_op(5'd1, c[19:0]));
		program_words.push_back(imm_op(cpu_isa_pkg::op_addi, 5'd2, 5'd1, ia));
		program_words.push_back(imm_op(cpu_isa_pkg::op_ori, 5'd3, 5'd1, io));
		program_words.push_back(imm_op(cpu_isa_pkg::op_xori, 5'd4, 5'd1, ix));
		program_words.push_back(reg_op(cpu_isa_pkg::sub_slli, 5'd5, 5'd1, s1));
		program_words.push_back(reg_op(cpu_isa_pkg::sub_srli, 5'd6, 5'd1, s2));
		program_words.push_back(reg_op(cpu_isa_pkg::sub_rotri, 5'd7, 5'd1, s3));
		start_program("immediates");
		both = {c, c} >> s3;
		expect_retire("movi", 32'd0, 1'b1, c);
		expect_retire("addi", 32'd4, 1'b1, c + sext(15, {17'd0, ia}));
		expect_retire("ori", 32'd8, 1'b1, c | {17'd0, io});
		expect_retire("xori", 32'd12, 1'b1, c ^ {17'd0, ix});
		expect_retire("slli", 32'd16, 1'b1, c << s1);
		expect_retire("srli", 32'd20, 1'b1, c >> s2);
		expect_retire("rotri", 32'd24, 1'b1, both[31:0]);
		finish_test;
	endtask

	task automatic mem_test;
		cpu_isa_pkg::word_t d1;
		cpu_isa_pkg::word_t d2;
		d1 = sext(20, $urandom);
		d2 = sext(20, $urandom);
		program_words.delete();
		program_words.push_back(movi_op(5'd1, d1[19:0]));
		program_words.push_back(movi_op(5'd2, d2[19:0]));
		program_words.push_back(imm_op(cpu_isa_pkg::op_swi, 5'd1, 5'd0, 15'd5));
		program_words.push_back(imm_op(cpu_isa_pkg::op_lwi, 5'd3, 5'd0, 15'd5));
		program_words.push_back(movi_op(5'd4, 20'd64));
		// offset -3 words from 64
		program_words.push_back(imm_op(cpu_isa_pkg::op_swi, 5'd2, 5'd4, 15'h7ffd));
		program_words.push_back(imm_op(cpu_isa_pkg::op_lwi, 5'd5, 5'd4, 15'h7ffd));
		program_words.push_back(movi_op(5'd6, 20'd3));
		// 64 + (3 << 2) is address 76, word 19
		program_words.push_back(ls_op(cpu_isa_pkg::sub_sw, 2'd2, 5'd1, 5'd4, 5'd6));
		program_words.push_back(ls_op(cpu_isa_pkg::sub_lw, 2'd2, 5'd7, 5'd4, 5'd6));
		program_words.push_back(imm_op(cpu_isa_pkg::op_lwi, 5'd8, 5'd0, 15'd19));
		program_words.push_back(ls_op(cpu_isa_pkg::sub_sw, 2'd3, 5'd2, 5'd0, 5'd6));
		program_words.push_back(ls_op(cpu_isa_pkg::sub_lw, 2'd3, 5'd9, 5'd0, 5'd6));
		start_program("load_store");
		expect_retire("movi r1", 32'd0, 1'b1, d1);
		expect_retire("movi r2", 32'd4, 1'b1, d2);
		expect_retire("swi", 32'd8, 1'b0, '0);
		expect_retire("lwi", 32'd12, 1'b1, d1);
		expect_retire("movi r4", 32'd16, 1'b1, 32'd64);
		expect_retire("swi negative", 32'd20, 1'b0, '0);
		expect_retire("lwi negative", 32'd24, 1'b1, d2);
		expect_retire("movi r6", 32'd28, 1'b1, 32'd3);
		expect_retire("sw sv2", 32'd32, 1'b0, '0);
		expect_retire("lw sv2", 32'd36, 1'b1, d1);
		expect_retire("lwi word 19", 32'd40, 1'b1, d1);
		expect_retire("sw sv3", 32'd44, 1'b0, '0);
		expect_retire("lw sv3", 32'd48, 1'b1, d2);
		finish_test;
	endtask

	task automatic flow_test;
		program_words.delete();
		program_words.push_back(movi_op(5'd1, 20'd7));
		program_words.push_back(movi_op(5'd2, 20'd7));
		program_words.push_back(movi_op(5'd3, 20'd9));
		program_words.push_back(branch_op(1'b0, 5'd1, 5'd2, 14'd4));
		program_words.push_back(movi_op(5'd4, 20'd1));
		program_words.push_back(branch_op(1'b1, 5'd1, 5'd2, 14'd4));
		program_words.push_back(branch_op(1'b0, 5'd1, 5'd3, 14'd4));
		program_words.push_back(branch_op(1'b1, 5'd1, 5'd3, 14'd4));
		program_words.push_back(movi_op(5'd4, 20'd2));
		program_words.push_back(jump_op(24'd6));
		program_words.push_back(movi_op(5'd4, 20'd3));
		program_words.push_back(movi_op(5'd4, 20'd3));
		program_words.push_back(movi_op(5'd5, 20'h55));
		start_program("control_flow");
		expect_retire("movi r1", 32'd0, 1'b1, 32'd7);
		expect_retire("movi r2", 32'd4, 1'b1, 32'd7);
		expect_retire("movi r3", 32'd8, 1'b1, 32'd9);
		expect_retire("beq taken", 32'd12, 1'b0, '0);
		// 12 + (4 << 1)
		expect_retire("bne not taken", 32'd20, 1'b0, '0);
		expect_retire("beq not taken", 32'd24, 1'b0, '0);
		expect_retire("bne taken", 32'd28, 1'b0, '0);
		expect_retire("j", 32'd36, 1'b0, '0);
		// 36 + (6 << 1)
		expect_retire("movi r5", 32'd48, 1'b1, 32'h55);
		check_register(5'd4, '0);
		finish_test;
	endtask

	task automatic unknown_op_test;
		cpu_isa_pkg::word_t x;
		cpu_isa_pkg::word_t y;
		x = sext(20, $urandom);
		y = sext(20, $urandom);
		program_words.delete();
		program_words.push_back(movi_op(5'd1, x[19:0]));
		program_words.push_back(movi_op(5'd2, y[19:0]));
		program_words.push_back(imm_op(6'b111111, 5'd1, 5'd2, 15'd0));
		program_words.push_back(reg_op(5'b11111, 5'd2, 5'd1, 5'd1));
		program_words.push_back(imm_op(cpu_isa_pkg::op_addi, 5'd3, 5'd0, 15'd5));
		start_program("unknown_op");
		expect_retire("movi r1", 32'd0, 1'b1, x);
		expect_retire("movi r2", 32'd4, 1'b1, y);
		expect_retire("bad opcode", 32'd8, 1'b0, '0);
		expect_retire("bad sub-opcode", 32'd12, 1'b0, '0);
		expect_retire("addi", 32'd16, 1'b1, 32'd5);
		check_register(5'd1, x);
		check_register(5'd2, y);
		finish_test;
	endtask

	initial begin
		reset = 1'b1;
		prog_write = 1'b0;
		prog_address = '0;
		prog_data = '0;
		debug_address = '0;
		void'($urandom(32'hadde));
		alu_reg_test;
		imm_test;
		mem_test;
		flow_test;
		unknown_op_test;
		$display("tests %0d, failed %0d, errors %0d, assertion failures %0d", tests_run,
			tests_failed, error_count, i_dut.i_checker.failures);
		if (error_count == 0 && tests_failed == 0 && i_dut.i_checker.failures == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// File: vlog.f
design/cpu_isa_pkg.sv
design/cpu_ctrl_pkg.sv
design/word_memory.sv
design/register_file.sv
design/alu.sv
design/controller.sv
design/cpu_top.sv
test/cpu_checker.sv
test/cpu_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = cpu_tb
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
LOG       = sim.log
SIM_ARGS  = +verilator+error+limit+100

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "TEST PASS" $(LOG) || { echo "simulation did not complete"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
